//--- all.f
+incdir+testbench
common/corePkg.sv
issue/regFile.sv
issue/scoreboard.sv
issue/issueStage.sv
hw/executeStage.sv
hw/commitStage.sv
hw/coreBackend.sv
testbench/backendTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall -j 0
TOP       ?= backendTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/backendModel.svh
// Architectural state, updated in program order at acceptance
logic [xlen-1:0] modelRegs [regCount];

typedef struct
{
	logic [regAddrWidth-1:0] rd;
	logic [xlen-1:0] data;
	int due;
} commitEntry;

commitEntry expQ[$];
int squashLeft;

// Writers expected in stage 4 and stage 5
logic hist4We;
logic [regAddrWidth-1:0] hist4Rd;
logic hist5We;
logic [regAddrWidth-1:0] hist5Rd;

// Branch expected in stage 4
logic expTaken;
logic [xlen-1:0] expTarget;

function automatic logic [xlen-1:0] readReg(input logic [regAddrWidth-1:0] r);
	return (r == 0) ? '0 : modelRegs[r];
endfunction

function automatic logic [xlen-1:0] aluModel(input aluOp op, input logic [xlen-1:0] a,
		input logic [xlen-1:0] b);
	logic [4:0] sh;
	logic [xlen-1:0] fill;
	sh = b[4:0];
	// Arithmetic shift built from a logical shift plus sign fill
	fill = a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0;
	case (op)
		aluAdd: return a + b;
		aluSub: return a + ~b + 1;
		aluSll: return a << sh;
		aluSlt: return (a[xlen-1] != b[xlen-1]) ? xlen'(a[xlen-1]) : xlen'(a < b);
		aluSltu: return xlen'(a < b);
		aluXor: return a ^ b;
		aluSrl: return a >> sh;
		aluSra: return (a >> sh) | fill;
		aluOr: return a | b;
		aluAnd: return a & b;
		default: return 'x;
	endcase
endfunction

function automatic logic pendingWrite(input logic [regAddrWidth-1:0] src);
	return src != 0 && ((hist4We && hist4Rd == src) || (hist5We && hist5Rd == src));
endfunction

task automatic modelStep(input logic accepted, input logic we, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input aluOp op, input bSel bs,
		input logic [xlen-1:0] imm, input logic [4:0] shamt, input logic br,
		input branchCond cond, input logic [xlen-1:0] pc, input int cycle);
	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [xlen-1:0] value;
	hist5We = hist4We;
	hist5Rd = hist4Rd;
	hist4We = 1'b0;
	expTaken = 1'b0;
	if (!accepted)
		return;
	if (squashLeft > 0)
	begin
		squashLeft--;
		return;
	end
	a = readReg(rs1);
	b = (bs == bSelImm) ? imm : (bs == bSelShamt) ? xlen'(shamt) : readReg(rs2);
	if (br)
	begin
		expTaken = (cond == condNe) ? (a != readReg(rs2)) : (a == readReg(rs2));
		expTarget = pc + imm;
		if (expTaken)
			squashLeft = squashSlots;
	end
	else if (we && rd != 0)
	begin
		value = aluModel(op, a, b);
		modelRegs[rd] = value;
		expQ.push_back('{rd, value, cycle + 2});
		hist4We = 1'b1;
		hist4Rd = rd;
	end
endtask

//--- testbench/backendTb.sv
module backendTb;
	import corePkg::*;

	`include "backendModel.svh"

	localparam int clkPeriod = 40;
	localparam int randomInsts = 300;
	localparam int plannedInsts = randomInsts + 120;

	logic clk;
	logic nrst;
	logic instWe;
	logic [regAddrWidth-1:0] instRd;
	logic [regAddrWidth-1:0] instRs1;
	logic [regAddrWidth-1:0] instRs2;
	aluOp instAluOp;
	bSel instBSel;
	logic [xlen-1:0] instImm;
	logic [shamtWidth-1:0] instShamt;
	logic instBranch;
	branchCond instBranchCond;
	logic [xlen-1:0] instPc;
	logic stall;
	logic commitWe;
	logic [regAddrWidth-1:0] commitRd;
	logic [xlen-1:0] commitData;
	logic branchTaken;
	logic [xlen-1:0] branchTarget;

	string testName;
	int cycle;
	int issued;
	logic [xlen-1:0] pcNext;
	logic expStall;
	logic expCommit;

	coreBackend dut_i (.*);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic stopWithFailure();
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic failValue(input string what, input logic [xlen-1:0] expVal,
			input logic [xlen-1:0] actVal);
		$display("FAILED %s %s: expected %h actual %h", testName, what, expVal, actVal);
		stopWithFailure();
	endtask

	// Present one instruction and wait until an edge accepts it
	task automatic issueInst(input logic we, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input aluOp op, input bSel bs, input logic [xlen-1:0] imm,
			input logic [4:0] shamt, input logic br, input branchCond cond);
		logic stallSeen;
		instWe <= we;
		instRd <= rd;
		instRs1 <= rs1;
		instRs2 <= rs2;
		instAluOp <= op;
		instBSel <= bs;
		instImm <= imm;
		instShamt <= shamt;
		instBranch <= br;
		instBranchCond <= cond;
		instPc <= pcNext;
		do
		begin
			@(negedge clk);
			stallSeen = stall;
			@(posedge clk);
			cycle++;
			modelStep(!stallSeen, we, rd, rs1, rs2, op, bs, imm, shamt, br, cond, pcNext, cycle);
		end
		while (stallSeen);
		pcNext = pcNext + 4;
		issued++;
	endtask

	task automatic nop();
		issueInst(1'b0, 5'd0, 5'd0, 5'd0, aluAdd, bSelReg, '0, '0, 1'b0, condEq);
	endtask

	task automatic aluInst(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
			input aluOp op);
		issueInst(1'b1, rd, rs1, rs2, op, bSelReg, '0, '0, 1'b0, condEq);
	endtask

	task automatic immInst(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [xlen-1:0] imm, input aluOp op);
		issueInst(1'b1, rd, rs1, 5'd0, op, bSelImm, imm, '0, 1'b0, condEq);
	endtask

	task automatic shamtInst(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] sh,
			input aluOp op);
		issueInst(1'b1, rd, rs1, 5'd0, op, bSelShamt, '0, sh, 1'b0, condEq);
	endtask

	task automatic branchInst(input logic [4:0] rs1, input logic [4:0] rs2,
			input branchCond cond, input logic [xlen-1:0] offset);
		issueInst(1'b0, 5'd0, rs1, rs2, aluAdd, bSelReg, offset, '0, 1'b1, cond);
	endtask

	// Outputs are compared mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (!nrst)
		begin
			assert (!commitWe && !stall && !branchTaken)
			else
			begin
				$display("Outputs not low during reset");
				stopWithFailure();
			end
		end
		else
		begin
			expCommit = expQ.size() > 0 && expQ[0].due == cycle;
			expStall = (pendingWrite(instRs1) || pendingWrite(instRs2)) && squashLeft == 0;
			assert (stall == expStall) else failValue("stall", xlen'(expStall), xlen'(stall));
			assert (branchTaken == expTaken)
			else failValue("branchTaken", xlen'(expTaken), xlen'(branchTaken));
			if (expTaken)
				assert (branchTarget == expTarget)
				else failValue("branchTarget", expTarget, branchTarget);
			assert (commitWe == expCommit)
			else failValue("commitWe", xlen'(expCommit), xlen'(commitWe));
			if (expCommit)
			begin
				assert (commitRd == expQ[0].rd)
				else failValue("commitRd", xlen'(expQ[0].rd), xlen'(commitRd));
				assert (commitData == expQ[0].data)
				else failValue("commitData", expQ[0].data, commitData);
				void'(expQ.pop_front());
			end
		end
	end

	initial
	begin
		#(longint'(plannedInsts * 40 + 200) * clkPeriod);
		$display("Timeout after %0d instructions issued", issued);
		stopWithFailure();
	end

	initial
	begin
		int kind;
		aluOp op;
		void'($urandom(32'h009b_36be));
		clk = 1'b0;
		nrst = 1'b0;
		instWe = 1'b0;
		instRd = '0;
		instRs1 = '0;
		instRs2 = '0;
		instAluOp = aluAdd;
		instBSel = bSelReg;
		instImm = '0;
		instShamt = '0;
		instBranch = 1'b0;
		instBranchCond = condEq;
		instPc = '0;
		for (int i = 0; i < regCount; i++)
			modelRegs[i] = '0;
		squashLeft = 0;
		hist4We = 1'b0;
		hist4Rd = '0;
		hist5We = 1'b0;
		hist5Rd = '0;
		expTaken = 1'b0;
		expTarget = '0;
		cycle = 0;
		issued = 0;
		pcNext = 32'h0000_1000;
		testName = "reset";
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		repeat (3) nop();

		testName = "alu";
		immInst(5'd1, 5'd0, 32'h1234_5678, aluAdd);
		immInst(5'd2, 5'd0, 32'hffff_fffb, aluAdd);
		repeat (3) nop();
		for (int i = 0; i < 10; i++)
		begin
			op = aluOp'(i);
			aluInst(5'(10 + i), 5'd1, 5'd2, op);
			immInst(5'(10 + i), 5'd2, 32'hffff_f803, op);
			shamtInst(5'(10 + i), 5'd1, 5'd7, op);
		end

		testName = "hazard";
		aluInst(5'd5, 5'd1, 5'd2, aluAdd);
		aluInst(5'd6, 5'd5, 5'd1, aluXor);
		nop();
		aluInst(5'd7, 5'd2, 5'd6, aluSub);
		aluInst(5'd8, 5'd1, 5'd1, aluAdd);
		nop();
		nop();
		aluInst(5'd9, 5'd8, 5'd8, aluOr);

		testName = "x0";
		aluInst(5'd0, 5'd1, 5'd2, aluAdd);
		aluInst(5'd11, 5'd0, 5'd1, aluAdd);
		aluInst(5'd12, 5'd1, 5'd0, aluSub);

		testName = "branch";
		branchInst(5'd1, 5'd1, condEq, 32'h40);
		aluInst(5'd20, 5'd1, 5'd1, aluAdd);
		aluInst(5'd21, 5'd20, 5'd1, aluAdd);
		aluInst(5'd22, 5'd1, 5'd2, aluAnd);
		branchInst(5'd1, 5'd2, condNe, 32'hffff_fff0);
		// First squashed slot reads x22 while it sits in stage 5
		immInst(5'd23, 5'd22, 32'd9, aluAdd);
		immInst(5'd24, 5'd23, 32'd9, aluAdd);
		branchInst(5'd1, 5'd2, condEq, 32'h80);
		immInst(5'd25, 5'd1, 32'd3, aluAdd);
		aluInst(5'd26, 5'd25, 5'd2, aluSltu);
		repeat (3) nop();

		testName = "random";
		for (int i = 0; i < randomInsts; i++)
		begin
			kind = $urandom % 10;
			op = aluOp'($urandom % 10);
			if (kind < 2)
				branchInst(5'($urandom % 8), 5'($urandom % 8), branchCond'($urandom % 2),
						xlen'(($urandom % 64) * 4));
			else if (kind == 2)
				nop();
			else if (kind < 6)
				aluInst(5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8), op);
			else if (kind < 8)
				immInst(5'($urandom % 8), 5'($urandom % 8), $urandom, op);
			else
				shamtInst(5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 32),
						($urandom % 3 == 0) ? aluSll : ($urandom % 2 == 0) ? aluSrl : aluSra);
		end

		testName = "drain";
		repeat (6) nop();
		if (expQ.size() != 0)
		begin
			$display("%0d expected commits never appeared", expQ.size());
			stopWithFailure();
		end
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

//--- hw/coreBackend.sv
module coreBackend (
	input logic clk,
	input logic nrst,

	// Decode side
	input logic instWe,
	input logic [corePkg::regAddrWidth-1:0] instRd,
	input logic [corePkg::regAddrWidth-1:0] instRs1,
	input logic [corePkg::regAddrWidth-1:0] instRs2,
	input corePkg::aluOp instAluOp,
	input corePkg::bSel instBSel,
	input logic [corePkg::xlen-1:0] instImm,
	input logic [corePkg::shamtWidth-1:0] instShamt,
	input logic instBranch,
	input corePkg::branchCond instBranchCond,
	input logic [corePkg::xlen-1:0] instPc,

	output logic stall,
	output logic commitWe,
	output logic [corePkg::regAddrWidth-1:0] commitRd,
	output logic [corePkg::xlen-1:0] commitData,
	output logic branchTaken,
	output logic [corePkg::xlen-1:0] branchTarget
);
	import corePkg::*;

	// Stage 4
	logic [xlen-1:0] opA;
	logic [xlen-1:0] opB;
	logic [regAddrWidth-1:0] rd4;
	logic we4;
	aluOp aluOp4;
	logic branch4;
	branchCond branchCond4;
	logic [xlen-1:0] pc4;
	logic [xlen-1:0] bImm4;

	// Stage 5
	logic we5;
	logic [regAddrWidth-1:0] rd5;
	logic [xlen-1:0] result5;

	// Stage 6, write-back
	logic wbWe;
	logic [regAddrWidth-1:0] wbRd;
	logic [xlen-1:0] wbData;

	issueStage issueStage_i (
		.clk(clk),
		.nrst(nrst),
		.we3(instWe),
		.rd3(instRd),
		.rs1(instRs1),
		.rs2(instRs2),
		.aluOp3(instAluOp),
		.bSel3(instBSel),
		.imm3(instImm),
		.shamt3(instShamt),
		.branch3(instBranch),
		.branchCond3(instBranchCond),
		.pc3(instPc),
		.wbWe(wbWe),
		.wbRd(wbRd),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.stall(stall),
		.opA(opA),
		.opB(opB),
		.rd4(rd4),
		.we4(we4),
		.aluOp4(aluOp4),
		.branch4(branch4),
		.branchCond4(branchCond4),
		.pc4(pc4),
		.bImm4(bImm4)
	);

	executeStage executeStage_i (
		.clk(clk),
		.nrst(nrst),
		.opA(opA),
		.opB(opB),
		.rd4(rd4),
		.we4(we4),
		.aluOp4(aluOp4),
		.branch4(branch4),
		.branchCond4(branchCond4),
		.pc4(pc4),
		.bImm4(bImm4),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.we5(we5),
		.rd5(rd5),
		.result5(result5)
	);

	commitStage commitStage_i (
		.clk(clk),
		.nrst(nrst),
		.we5(we5),
		.rd5(rd5),
		.result5(result5),
		.wbWe(wbWe),
		.wbRd(wbRd),
		.wbData(wbData)
	);

	assign commitWe = wbWe;
	assign commitRd = wbRd;
	assign commitData = wbData;

endmodule

//--- hw/commitStage.sv
module commitStage (
	input logic clk,
	input logic nrst,
	input logic we5,
	input logic [corePkg::regAddrWidth-1:0] rd5,
	input logic [corePkg::xlen-1:0] result5,
	output logic wbWe,
	output logic [corePkg::regAddrWidth-1:0] wbRd,
	output logic [corePkg::xlen-1:0] wbData
);

	// x0 writes die here, so neither the register file nor the outside sees them
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wbWe <= 1'b0;
		else
			wbWe <= we5 && rd5 != '0;
	end

	always_ff @(posedge clk)
	begin
		wbRd <= rd5;
		wbData <= result5;
	end

endmodule

//--- hw/executeStage.sv
module executeStage (
	input logic clk,
	input logic nrst,
	input logic [corePkg::xlen-1:0] opA,
	input logic [corePkg::xlen-1:0] opB,
	input logic [corePkg::regAddrWidth-1:0] rd4,
	input logic we4,
	input corePkg::aluOp aluOp4,
	input logic branch4,
	input corePkg::branchCond branchCond4,
	input logic [corePkg::xlen-1:0] pc4,
	input logic [corePkg::xlen-1:0] bImm4,
	output logic branchTaken,
	output logic [corePkg::xlen-1:0] branchTarget,
	output logic we5,
	output logic [corePkg::regAddrWidth-1:0] rd5,
	output logic [corePkg::xlen-1:0] result5
);
	import corePkg::*;

	logic [xlen-1:0] aluResult;
	logic [shamtWidth-1:0] shift;
	logic equal;

	assign shift = opB[shamtWidth-1:0];

	always_comb
	begin
		case (aluOp4)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluSll: aluResult = opA << shift;
			aluSlt: aluResult = xlen'($signed(opA) < $signed(opB));
			aluSltu: aluResult = xlen'(opA < opB);
			aluXor: aluResult = opA ^ opB;
			aluSrl: aluResult = opA >> shift;
			aluSra: aluResult = $unsigned($signed(opA) >>> shift);
			aluOr: aluResult = opA | opB;
			aluAnd: aluResult = opA & opB;
			default: aluResult = opA + opB;
		endcase
	end

	// Branch resolution
	assign equal = opA == opB;

	always_comb
	begin
		case (branchCond4)
			condEq: branchTaken = branch4 && equal;
			condNe: branchTaken = branch4 && !equal;
			default: branchTaken = 1'b0;
		endcase
	end

	assign branchTarget = pc4 + bImm4;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			we5 <= 1'b0;
		else
			// A branch never writes back
			we5 <= we4 && !branch4;
	end

	always_ff @(posedge clk)
	begin
		rd5 <= rd4;
		result5 <= aluResult;
	end

endmodule

//--- issue/issueStage.sv
module issueStage (
	input logic clk,
	input logic nrst,

	// Decoded instruction
	input logic we3,
	input logic [corePkg::regAddrWidth-1:0] rd3,
	input logic [corePkg::regAddrWidth-1:0] rs1,
	input logic [corePkg::regAddrWidth-1:0] rs2,
	input corePkg::aluOp aluOp3,
	input corePkg::bSel bSel3,
	input logic [corePkg::xlen-1:0] imm3,
	input logic [corePkg::shamtWidth-1:0] shamt3,
	input logic branch3,
	input corePkg::branchCond branchCond3,
	input logic [corePkg::xlen-1:0] pc3,

	// Write-back from commit
	input logic wbWe,
	input logic [corePkg::regAddrWidth-1:0] wbRd,
	input logic [corePkg::xlen-1:0] wbData,

	input logic branchTaken,
	output logic stall,

	// Stage 4
	output logic [corePkg::xlen-1:0] opA,
	output logic [corePkg::xlen-1:0] opB,
	output logic [corePkg::regAddrWidth-1:0] rd4,
	output logic we4,
	output corePkg::aluOp aluOp4,
	output logic branch4,
	output corePkg::branchCond branchCond4,
	output logic [corePkg::xlen-1:0] pc4,
	output logic [corePkg::xlen-1:0] bImm4
);
	import corePkg::*;

	logic [xlen-1:0] rfDataA;
	logic [xlen-1:0] rfDataB;
	logic [xlen-1:0] regB4;
	logic [shamtWidth-1:0] shamt4;
	bSel bSel4;
	logic kill;

	regFile regFile_i (
		.clk(clk),
		.nrst(nrst),
		.we(wbWe),
		.writeAddr(wbRd),
		.writeData(wbData),
		.readAddrA(rs1),
		.readAddrB(rs2),
		.readDataA(rfDataA),
		.readDataB(rfDataB)
	);

	scoreboard scoreboard_i (
		.clk(clk),
		.nrst(nrst),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd3),
		.we(we3),
		.rd4(rd4),
		.we4(we4),
		.branchTaken(branchTaken),
		.stall(stall),
		.kill(kill)
	);

	// Control, a bubble goes in on stall or kill
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			we4 <= 1'b0;
			branch4 <= 1'b0;
			rd4 <= '0;
		end
		else if (stall || kill)
		begin
			we4 <= 1'b0;
			branch4 <= 1'b0;
			rd4 <= '0;
		end
		else
		begin
			we4 <= we3;
			branch4 <= branch3;
			rd4 <= rd3;
		end
	end

	// Payload, only meaningful behind an enable
	always_ff @(posedge clk)
	begin
		opA <= rfDataA;
		regB4 <= rfDataB;
		bImm4 <= imm3;
		shamt4 <= shamt3;
		bSel4 <= bSel3;
		aluOp4 <= aluOp3;
		branchCond4 <= branchCond3;
		pc4 <= pc3;
	end

	// Branches take the register value here, the immediate is their offset
	always_comb
	begin
		case (bSel4)
			bSelReg: opB = regB4;
			bSelImm: opB = bImm4;
			bSelShamt: opB = xlen'(shamt4);
			default: opB = regB4;
		endcase
	end

endmodule

//--- issue/scoreboard.sv
module scoreboard (
	input logic clk,
	input logic nrst,
	input logic [corePkg::regAddrWidth-1:0] rs1,
	input logic [corePkg::regAddrWidth-1:0] rs2,
	input logic [corePkg::regAddrWidth-1:0] rd,
	input logic we,
	input logic [corePkg::regAddrWidth-1:0] rd4,
	input logic we4,
	input logic branchTaken,
	output logic stall,
	output logic kill
);
	import corePkg::*;

	// Destination accepted last edge, shifts on into the stage 5 slot
	logic [regAddrWidth-1:0] pendRd;
	logic pendWe;
	logic [regAddrWidth-1:0] rd5;
	logic we5;
	logic [killCountWidth-1:0] killCount;
	logic hazard;

	function automatic logic hits(input logic [regAddrWidth-1:0] src,
			input logic [regAddrWidth-1:0] dst, input logic dstWe);
		return dstWe && src != '0 && src == dst;
	endfunction

	assign kill = branchTaken || killCount != '0;

	// Stage 6 is left to the register file write-through
	assign hazard = hits(rs1, rd4, we4) || hits(rs2, rd4, we4) ||
			hits(rs1, rd5, we5) || hits(rs2, rd5, we5);

	// A squashed instruction never waits
	assign stall = hazard && !kill;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pendRd <= '0;
			pendWe <= 1'b0;
			rd5 <= '0;
			we5 <= 1'b0;
		end
		else
		begin
			pendRd <= rd;
			pendWe <= we && !stall && !kill && rd != '0;
			rd5 <= pendRd;
			we5 <= pendWe;
		end
	end

	// Branch edge squashes the first slot, the counter covers the rest
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			killCount <= '0;
		else if (branchTaken)
			killCount <= killCountWidth'(squashSlots - 1);
		else if (killCount != '0)
			killCount <= killCount - 1'b1;
	end

endmodule

//--- issue/regFile.sv
module regFile (
	input logic clk,
	input logic nrst,
	input logic we,
	input logic [corePkg::regAddrWidth-1:0] writeAddr,
	input logic [corePkg::xlen-1:0] writeData,
	input logic [corePkg::regAddrWidth-1:0] readAddrA,
	input logic [corePkg::regAddrWidth-1:0] readAddrB,
	output logic [corePkg::xlen-1:0] readDataA,
	output logic [corePkg::xlen-1:0] readDataB
);
	import corePkg::*;

	logic [xlen-1:0] regs [regCount];

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (we && writeAddr != '0)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 reads zero, same-cycle write is forwarded
	always_comb
	begin
		if (readAddrA == '0)
			readDataA = '0;
		else if (we && writeAddr == readAddrA)
			readDataA = writeData;
		else
			readDataA = regs[readAddrA];

		if (readAddrB == '0)
			readDataB = '0;
		else if (we && writeAddr == readAddrB)
			readDataB = writeData;
		else
			readDataB = regs[readAddrB];
	end

endmodule

//--- common/corePkg.sv
package corePkg;

	// Datapath widths
	localparam int xlen = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 1 << regAddrWidth;
	localparam int shamtWidth = 5;

	// Accepted slots thrown away behind a taken branch
	localparam int squashSlots = 2;
	localparam int killCountWidth = 2;

	// ALU operations, RV32I integer subset
	typedef enum logic [3:0]
	{
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOp;

	// Where operand B comes from
	typedef enum logic [1:0]
	{
		bSelReg   = 2'd0,
		bSelImm   = 2'd1,
		bSelShamt = 2'd2
	} bSel;

	// Conditional branch compare
	typedef enum logic
	{
		condEq = 1'b0,
		condNe = 1'b1
	} branchCond;

endpackage
